// ==== hdl/sdfm_macros.svh ====
//============================================================
// sdfm register map constants: device id, offsets, sizes,
// bit positions inside the IFLG word
//============================================================
`ifndef SDFM_MACROS_SVH
`define SDFM_MACROS_SVH

// upper address byte of this device
`define SDFM_DEVICE_ID     8'h07

// register offsets, channel x at offset + 4*x
`define SDFM_ADDR_IFLG     8'h00
`define SDFM_ADDR_IFLGCLR  8'h04
`define SDFM_ADDR_CTL      8'h08
`define SDFM_ADDR_CPARM    8'h1C
`define SDFM_ADDR_CMPL     8'h24
`define SDFM_ADDR_CMPH     8'h2C
`define SDFM_ADDR_CDATA    8'h44

`define SDFM_NCH           2    // comparator channels
`define SDFM_DW            32   // bus word width

// IFLG / IFLGCLR layout
`define SDFM_IFLG_LF_BIT   8    // LFx at 8+x
`define SDFM_IFLG_HF_BIT   12   // HFx at 12+x
`define SDFM_IFLG_IRQF_BIT 31   // latched irq

`endif

// ==== hdl/sdfm_pkg.sv ====
//============================================================
// sdfm types: CPARM word layout and read selection kinds
//============================================================
`default_nettype none

`include "sdfm_macros.svh"

package sdfm_pkg;

  // CPARMx fields, msb first
  typedef struct packed {
    logic [9:0] rsvd31_22;
    logic       hclrflg;     // bit 21, hw clear of HF
    logic       lclrflg;     // bit 20, hw clear of LF
    logic [1:0] rsvd19_18;
    logic       ihen;        // bit 17
    logic       ilen;        // bit 16
    logic [1:0] rsvd15_14;
    logic [1:0] st;          // bits 13..12, filter structure
    logic [1:0] rsvd11_10;
    logic       sen;         // bit 9, signed compare
    logic       cen;         // bit 8, comparator enable
    logic [7:0] dosr;        // bits 7..0, oversampling ratio
  } cparm_fields_t;

  // same word seen as fields or as a bus word
  typedef union packed {
    cparm_fields_t          f;
    logic [`SDFM_DW-1:0]    raw;
  } cparm_word_t;

  // which register the read mux returns
  typedef enum logic [2:0] {
    KIND_NONE  = 3'd0,
    KIND_IFLG  = 3'd1,
    KIND_CTL   = 3'd2,
    KIND_CPARM = 3'd3,
    KIND_CMPL  = 3'd4,
    KIND_CMPH  = 3'd5,
    KIND_CDATA = 3'd6
  } reg_kind_t;

endpackage

`default_nettype wire

// ==== hdl/sdfm_bus_decode.sv ====
//============================================================
// address decode: device select, write strobes, read select
//============================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdfm_macros.svh"

module sdfm_bus_decode
  import sdfm_pkg::*;
(
  input  wire logic [15:0]                   addr,
  input  wire logic                          wr,
  input  wire logic                          rd,
  output logic                               ctl_we,
  output logic                               iflgclr_we,
  output logic [`SDFM_NCH-1:0]               cparm_we,
  output logic [`SDFM_NCH-1:0]               cmpl_we,
  output logic [`SDFM_NCH-1:0]               cmph_we,
  output reg_kind_t                          rd_kind,
  output logic [$clog2(`SDFM_NCH)-1:0]       rd_ch
);

  localparam int CHW = $clog2(`SDFM_NCH);

  logic       dev_sel;  // our device id on the upper byte
  logic [7:0] off;      // register offset

  assign dev_sel = (addr[15:8] == `SDFM_DEVICE_ID) && (wr || rd);
  assign off     = addr[7:0];

  always_comb
  begin
    ctl_we     = 1'b0;
    iflgclr_we = 1'b0;
    cparm_we   = '0;
    cmpl_we    = '0;
    cmph_we    = '0;
    rd_kind    = KIND_NONE;
    rd_ch      = '0;
    if (dev_sel)
    begin
      // global registers
      if (off == `SDFM_ADDR_IFLG && rd)
        rd_kind = KIND_IFLG;
      if (off == `SDFM_ADDR_IFLGCLR)
        iflgclr_we = wr;            // write only, reads zero
      if (off == `SDFM_ADDR_CTL)
      begin
        ctl_we = wr;
        if (rd)
          rd_kind = KIND_CTL;
      end
      // per channel banks, stride 4
      for (int ch = 0; ch < `SDFM_NCH; ch++)
      begin
        if (off == 8'(`SDFM_ADDR_CPARM + 4 * ch))
        begin
          cparm_we[ch] = wr;
          if (rd)
          begin
            rd_kind = KIND_CPARM;
            rd_ch   = CHW'(ch);
          end
        end
        if (off == 8'(`SDFM_ADDR_CMPL + 4 * ch))
        begin
          cmpl_we[ch] = wr;
          if (rd)
          begin
            rd_kind = KIND_CMPL;
            rd_ch   = CHW'(ch);
          end
        end
        if (off == 8'(`SDFM_ADDR_CMPH + 4 * ch))
        begin
          cmph_we[ch] = wr;
          if (rd)
          begin
            rd_kind = KIND_CMPH;
            rd_ch   = CHW'(ch);
          end
        end
        if (off == 8'(`SDFM_ADDR_CDATA + 4 * ch) && rd)
        begin
          rd_kind = KIND_CDATA;     // captured data, read only
          rd_ch   = CHW'(ch);
        end
      end
    end
  end

  // only one register may take a write in any cycle
  always_comb
  begin
    a_one_write: assert #0 ($onehot0({ctl_we, iflgclr_we, cparm_we, cmpl_we, cmph_we}));
  end

endmodule

`default_nettype wire

// ==== hdl/sdfm_comp_channel.sv ====
//============================================================
// one comparator channel: CPARM, CMPL/CMPH, CDATA, LF/HF
//============================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdfm_macros.svh"

module sdfm_comp_channel
  import sdfm_pkg::*;
#(
  parameter int CH = 0                      // channel index, picks IFLGCLR bits
)
(
  input  wire logic                  SYSCLK,
  input  wire logic                  SYSRSTn,
  input  wire logic                  cparm_we,
  input  wire logic                  cmpl_we,
  input  wire logic                  cmph_we,
  input  wire logic                  iflgclr_we,
  input  wire logic [`SDFM_DW-1:0]   wdata,
  input  wire logic                  comp_update,   // new comparator sample
  input  wire logic [`SDFM_DW-1:0]   comp_data,
  input  wire logic                  comp_low,      // sample below CMPL
  input  wire logic                  comp_high,     // sample at or above CMPH
  output logic [`SDFM_DW-1:0]        cparm_raw,
  output logic [7:0]                 dosr,
  output logic                       cen,
  output logic                       sen,
  output logic [1:0]                 st,
  output logic                       ilen,
  output logic                       ihen,
  output logic                       lclrflg,
  output logic                       hclrflg,
  output logic [`SDFM_DW-1:0]        cmpl,
  output logic [`SDFM_DW-1:0]        cmph,
  output logic [`SDFM_DW-1:0]        cdata,
  output logic                       lf,
  output logic                       hf
);

  cparm_word_t cparm_in;   // bus word seen as CPARM fields
  cparm_word_t cparm_wr;   // defined fields only
  cparm_word_t cparm_q;
  logic        lf_swclr;   // software clear of this channel's LF
  logic        hf_swclr;

  //============================================================
  // CPARMx
  //============================================================
  assign cparm_in.raw = wdata;

  always_comb
  begin
    cparm_wr.raw       = '0;                   // reserved bits stay zero
    cparm_wr.f.dosr    = cparm_in.f.dosr;
    cparm_wr.f.cen     = cparm_in.f.cen;
    cparm_wr.f.sen     = cparm_in.f.sen;
    cparm_wr.f.st      = cparm_in.f.st;
    cparm_wr.f.ilen    = cparm_in.f.ilen;
    cparm_wr.f.ihen    = cparm_in.f.ihen;
    cparm_wr.f.lclrflg = cparm_in.f.lclrflg;
    cparm_wr.f.hclrflg = cparm_in.f.hclrflg;
  end

  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
      cparm_q.raw <= '0;
    else if (cparm_we)
      cparm_q <= cparm_wr;
  end

  assign cparm_raw = cparm_q.raw;
  assign dosr      = cparm_q.f.dosr;
  assign cen       = cparm_q.f.cen;
  assign sen       = cparm_q.f.sen;
  assign st        = cparm_q.f.st;
  assign ilen      = cparm_q.f.ilen;
  assign ihen      = cparm_q.f.ihen;
  assign lclrflg   = cparm_q.f.lclrflg;
  assign hclrflg   = cparm_q.f.hclrflg;

  //============================================================
  // thresholds and captured data
  //============================================================
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      cmpl  <= '0;
      cmph  <= '0;
      cdata <= '0;
    end
    else
    begin
      if (cmpl_we)
        cmpl <= wdata;
      if (cmph_we)
        cmph <= wdata;
      if (comp_update)
        cdata <= comp_data;           // latest comparator sample
    end
  end

  //============================================================
  // LF / HF flags
  //============================================================
  assign lf_swclr = iflgclr_we && wdata[`SDFM_IFLG_LF_BIT + CH];
  assign hf_swclr = iflgclr_we && wdata[`SDFM_IFLG_HF_BIT + CH];

  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      lf <= 1'b0;
      hf <= 1'b0;
    end
    else
    begin
      if (comp_update && lclrflg)
        lf <= comp_low;               // hw clear mode, follows sample
      else if (comp_update && comp_low)
        lf <= 1'b1;                   // sticky set
      else if (!comp_update && lf_swclr)
        lf <= 1'b0;                   // update beats sw clear
      if (comp_update && hclrflg)
        hf <= comp_high;
      else if (comp_update && comp_high)
        hf <= 1'b1;
      else if (!comp_update && hf_swclr)
        hf <= 1'b0;
    end
  end

  // LF moves only on a sample or an IFLGCLR write
  a_lf_cause: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn)
    $changed(lf) |-> $past(comp_update || iflgclr_we));

endmodule

`default_nettype wire

// ==== hdl/sdfm_ctl_irq_read.sv ====
//============================================================
// CTL register, IRQF latch, IFLG word and read-back mux
//============================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdfm_macros.svh"

module sdfm_ctl_irq_read
  import sdfm_pkg::*;
(
  input  wire logic                          SYSCLK,
  input  wire logic                          SYSRSTn,
  input  wire logic                          ctl_we,
  input  wire logic                          iflgclr_we,
  input  wire logic [`SDFM_DW-1:0]           wdata,
  input  wire reg_kind_t                     rd_kind,
  input  wire logic [$clog2(`SDFM_NCH)-1:0]  rd_ch,
  input  wire logic [`SDFM_NCH-1:0]          lf,
  input  wire logic [`SDFM_NCH-1:0]          hf,
  input  wire logic [`SDFM_NCH-1:0]          ilen,
  input  wire logic [`SDFM_NCH-1:0]          ihen,
  input  wire logic [`SDFM_NCH*`SDFM_DW-1:0] cparm_raw,
  input  wire logic [`SDFM_NCH*`SDFM_DW-1:0] cmpl,
  input  wire logic [`SDFM_NCH*`SDFM_DW-1:0] cmph,
  input  wire logic [`SDFM_NCH*`SDFM_DW-1:0] cdata,
  output logic [`SDFM_DW-1:0]                rdata,
  output logic                               irq,
  output logic                               rsten,
  output logic                               clken
);

  logic                mien;       // master interrupt enable
  logic                irq_set;    // some enabled flag is up
  logic [`SDFM_DW-1:0] iflg_word;
  logic [`SDFM_DW-1:0] ctl_word;

  //============================================================
  // CTL
  //============================================================
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      rsten <= 1'b0;
      clken <= 1'b0;
      mien  <= 1'b0;
    end
    else if (ctl_we)
    begin
      rsten <= wdata[0];
      clken <= wdata[1];
      mien  <= wdata[4];
    end
  end

  //============================================================
  // IRQF
  //============================================================
  assign irq_set = mien && (|(lf & ilen) || |(hf & ihen));

  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
      irq <= 1'b0;
    else if (irq_set)
      irq <= 1'b1;                      // set wins over the clear
    else if (iflgclr_we && wdata[`SDFM_IFLG_IRQF_BIT])
      irq <= 1'b0;
  end

  // IFLG and CTL read words with AF bits held at zero
  always_comb
  begin
    iflg_word                           = '0;
    iflg_word[`SDFM_IFLG_LF_BIT +: `SDFM_NCH] = lf;
    iflg_word[`SDFM_IFLG_HF_BIT +: `SDFM_NCH] = hf;
    iflg_word[`SDFM_IFLG_IRQF_BIT]      = irq;
  end

  always_comb
  begin
    ctl_word    = '0;
    ctl_word[0] = rsten;
    ctl_word[1] = clken;
    ctl_word[4] = mien;
  end

  // read-back mux returns zero when nothing is selected
  always_comb
  begin
    case (rd_kind)
      KIND_IFLG:  rdata = iflg_word;
      KIND_CTL:   rdata = ctl_word;
      KIND_CPARM: rdata = cparm_raw[rd_ch * `SDFM_DW +: `SDFM_DW];
      KIND_CMPL:  rdata = cmpl[rd_ch * `SDFM_DW +: `SDFM_DW];
      KIND_CMPH:  rdata = cmph[rd_ch * `SDFM_DW +: `SDFM_DW];
      KIND_CDATA: rdata = cdata[rd_ch * `SDFM_DW +: `SDFM_DW];
      default:    rdata = '0;
    endcase
  end

  // an irq edge needs mien set in the cycle before
  a_irq_mien: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn)
    $rose(irq) |-> $past(mien));

endmodule

`default_nettype wire

// ==== hdl/sdfm_regmap.sv ====
//============================================================
// sdfm register map top: decoder, channels, ctl/irq/read
//============================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdfm_macros.svh"

module sdfm_regmap
(
  input  wire logic                          SYSCLK,
  input  wire logic                          SYSRSTn,
  input  wire logic                          wr,
  input  wire logic                          rd,
  input  wire logic [15:0]                   addr,
  input  wire logic [`SDFM_DW-1:0]           wdata,
  output logic [`SDFM_DW-1:0]                rdata,
  output logic                               irq,
  output logic                               rsten,
  output logic                               clken,
  // comparator parameters, per channel
  output logic [`SDFM_NCH*8-1:0]             dosr,
  output logic [`SDFM_NCH-1:0]               cen,
  output logic [`SDFM_NCH-1:0]               sen,
  output logic [`SDFM_NCH*2-1:0]             st,
  output logic [`SDFM_NCH-1:0]               ilen,
  output logic [`SDFM_NCH-1:0]               ihen,
  output logic [`SDFM_NCH-1:0]               lclrflg,
  output logic [`SDFM_NCH-1:0]               hclrflg,
  output logic [`SDFM_NCH*`SDFM_DW-1:0]      cmpl,
  output logic [`SDFM_NCH*`SDFM_DW-1:0]      cmph,
  // comparator results, per channel
  input  wire logic [`SDFM_NCH-1:0]          comp_update,
  input  wire logic [`SDFM_NCH*`SDFM_DW-1:0] comp_data,
  input  wire logic [`SDFM_NCH-1:0]          comp_low,
  input  wire logic [`SDFM_NCH-1:0]          comp_high
);

  logic                              ctl_we;
  logic                              iflgclr_we;
  logic [`SDFM_NCH-1:0]              cparm_we;
  logic [`SDFM_NCH-1:0]              cmpl_we;
  logic [`SDFM_NCH-1:0]              cmph_we;
  sdfm_pkg::reg_kind_t               rd_kind;
  logic [$clog2(`SDFM_NCH)-1:0]      rd_ch;
  logic [`SDFM_NCH-1:0]              lf;
  logic [`SDFM_NCH-1:0]              hf;
  logic [`SDFM_NCH*`SDFM_DW-1:0]     cparm_raw;
  logic [`SDFM_NCH*`SDFM_DW-1:0]     cdata;

  sdfm_bus_decode u_decode (
    .addr       (addr),
    .wr         (wr),
    .rd         (rd),
    .ctl_we     (ctl_we),
    .iflgclr_we (iflgclr_we),
    .cparm_we   (cparm_we),
    .cmpl_we    (cmpl_we),
    .cmph_we    (cmph_we),
    .rd_kind    (rd_kind),
    .rd_ch      (rd_ch)
  );

  //============================================================
  // comparator channels
  //============================================================
  for (genvar i = 0; i < `SDFM_NCH; i++)
  begin : g_ch
    sdfm_comp_channel #(.CH(i)) u_ch (
      .SYSCLK      (SYSCLK),
      .SYSRSTn     (SYSRSTn),
      .cparm_we    (cparm_we[i]),
      .cmpl_we     (cmpl_we[i]),
      .cmph_we     (cmph_we[i]),
      .iflgclr_we  (iflgclr_we),
      .wdata       (wdata),
      .comp_update (comp_update[i]),
      .comp_data   (comp_data[i*`SDFM_DW +: `SDFM_DW]),
      .comp_low    (comp_low[i]),
      .comp_high   (comp_high[i]),
      .cparm_raw   (cparm_raw[i*`SDFM_DW +: `SDFM_DW]),
      .dosr        (dosr[i*8 +: 8]),
      .cen         (cen[i]),
      .sen         (sen[i]),
      .st          (st[i*2 +: 2]),
      .ilen        (ilen[i]),
      .ihen        (ihen[i]),
      .lclrflg     (lclrflg[i]),
      .hclrflg     (hclrflg[i]),
      .cmpl        (cmpl[i*`SDFM_DW +: `SDFM_DW]),
      .cmph        (cmph[i*`SDFM_DW +: `SDFM_DW]),
      .cdata       (cdata[i*`SDFM_DW +: `SDFM_DW]),
      .lf          (lf[i]),
      .hf          (hf[i])
    );
  end

  sdfm_ctl_irq_read u_ctl (
    .SYSCLK     (SYSCLK),
    .SYSRSTn    (SYSRSTn),
    .ctl_we     (ctl_we),
    .iflgclr_we (iflgclr_we),
    .wdata      (wdata),
    .rd_kind    (rd_kind),
    .rd_ch      (rd_ch),
    .lf         (lf),
    .hf         (hf),
    .ilen       (ilen),
    .ihen       (ihen),
    .cparm_raw  (cparm_raw),
    .cmpl       (cmpl),
    .cmph       (cmph),
    .cdata      (cdata),
    .rdata      (rdata),
    .irq        (irq),
    .rsten      (rsten),
    .clken      (clken)
  );

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
//============================================================
// testbench clock source, free running
//============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
  parameter int PERIOD = 40                 // ns
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== test/tb_sdfm_regmap.sv ====
//============================================================
// sdfm register map testbench with stimulus, shadow model,
// compare process, watchdog and report
//============================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdfm_macros.svh"

module tb_sdfm_regmap;

  localparam int NCH         = `SDFM_NCH;
  localparam int DW          = `SDFM_DW;
  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int SEED        = 54161;
  localparam int TEST_CYCLES = RST_CYCLES + 360;  // rough sum over all tests
  localparam logic [DW-1:0] CTL_MASK   = 32'h0000_0013;  // rsten, clken, mien
  localparam logic [DW-1:0] CPARM_MASK = 32'h0033_33FF;  // defined CPARM fields
  localparam int MIEN_BIT    = 4;
  localparam int ILEN_BIT    = 16;
  localparam int IHEN_BIT    = 17;
  localparam int LCLR_BIT    = 20;
  localparam int HCLR_BIT    = 21;

  logic                SYSCLK;
  logic                SYSRSTn;
  logic                wr;
  logic                rd;
  logic [15:0]         addr;
  logic [DW-1:0]       wdata;
  logic [DW-1:0]       rdata;
  logic                irq;
  logic                rsten;
  logic                clken;
  logic [NCH*8-1:0]    dosr;
  logic [NCH-1:0]      cen;
  logic [NCH-1:0]      sen;
  logic [NCH*2-1:0]    st;
  logic [NCH-1:0]      ilen;
  logic [NCH-1:0]      ihen;
  logic [NCH-1:0]      lclrflg;
  logic [NCH-1:0]      hclrflg;
  logic [NCH*DW-1:0]   cmpl;
  logic [NCH*DW-1:0]   cmph;
  logic [NCH-1:0]      comp_update;
  logic [NCH*DW-1:0]   comp_data;
  logic [NCH-1:0]      comp_low;
  logic [NCH-1:0]      comp_high;

  // shadow model of the register contents
  logic [DW-1:0]       m_ctl;
  logic [DW-1:0]       m_cparm [NCH];
  logic [DW-1:0]       m_cmpl  [NCH];
  logic [DW-1:0]       m_cmph  [NCH];
  logic [DW-1:0]       m_cdata [NCH];
  logic [NCH-1:0]      m_lf;
  logic [NCH-1:0]      m_hf;
  logic                m_irq;

  int errors;
  int checks;
  int tests;
  int test_err0;       // error count when the current test began

  tb_clkgen #(.PERIOD(CLK_PERIOD)) clk_i (.clk(SYSCLK));

  sdfm_regmap dut_i (
    .SYSCLK (SYSCLK), .SYSRSTn (SYSRSTn), .wr (wr), .rd (rd), .addr (addr),
    .wdata (wdata), .rdata (rdata), .irq (irq), .rsten (rsten), .clken (clken),
    .dosr (dosr), .cen (cen), .sen (sen), .st (st), .ilen (ilen), .ihen (ihen),
    .lclrflg (lclrflg), .hclrflg (hclrflg), .cmpl (cmpl), .cmph (cmph),
    .comp_update (comp_update), .comp_data (comp_data),
    .comp_low (comp_low), .comp_high (comp_high)
  );

  //============================================================
  // reference model
  //============================================================
  function automatic logic [15:0] reg_addr(input logic [7:0] off, input int ch);
    return {`SDFM_DEVICE_ID, 8'(off + 4 * ch)};
  endfunction

  function automatic bit is_mapped(input logic [7:0] off);
    bit hit;
    hit = (off == `SDFM_ADDR_IFLG) || (off == `SDFM_ADDR_IFLGCLR) || (off == `SDFM_ADDR_CTL);
    for (int ch = 0; ch < NCH; ch++)
    begin
      hit = hit || (off == 8'(`SDFM_ADDR_CPARM + 4 * ch)) || (off == 8'(`SDFM_ADDR_CMPL + 4 * ch))
                || (off == 8'(`SDFM_ADDR_CMPH + 4 * ch)) || (off == 8'(`SDFM_ADDR_CDATA + 4 * ch));
    end
    return hit;
  endfunction

  // expected rdata for a read of address a
  function automatic logic [DW-1:0] ref_rdata(input logic [15:0] a);
    logic [DW-1:0] exp;
    exp = '0;
    if (a[15:8] == `SDFM_DEVICE_ID)
    begin
      if (a[7:0] == `SDFM_ADDR_IFLG)
      begin
        exp[`SDFM_IFLG_LF_BIT +: NCH] = m_lf;
        exp[`SDFM_IFLG_HF_BIT +: NCH] = m_hf;
        exp[`SDFM_IFLG_IRQF_BIT]      = m_irq;   // AF bits stay zero
      end
      if (a[7:0] == `SDFM_ADDR_CTL)
        exp = m_ctl;
      for (int ch = 0; ch < NCH; ch++)
      begin
        if (a[7:0] == 8'(`SDFM_ADDR_CPARM + 4 * ch))
          exp = m_cparm[ch];
        if (a[7:0] == 8'(`SDFM_ADDR_CMPL + 4 * ch))
          exp = m_cmpl[ch];
        if (a[7:0] == 8'(`SDFM_ADDR_CMPH + 4 * ch))
          exp = m_cmph[ch];
        if (a[7:0] == 8'(`SDFM_ADDR_CDATA + 4 * ch))
          exp = m_cdata[ch];
      end
    end
    return exp;
  endfunction

  // decoded CPARM outputs of one channel put back at their bit positions
  function automatic logic [DW-1:0] cparm_outputs(input int ch);
    logic [DW-1:0] w;
    w           = '0;
    w[7:0]      = dosr[ch*8 +: 8];
    w[8]        = cen[ch];
    w[9]        = sen[ch];
    w[13:12]    = st[ch*2 +: 2];
    w[ILEN_BIT] = ilen[ch];
    w[IHEN_BIT] = ihen[ch];
    w[LCLR_BIT] = lclrflg[ch];
    w[HCLR_BIT] = hclrflg[ch];
    return w;
  endfunction

  task automatic model_reset();
    m_ctl = '0;
    m_lf  = '0;
    m_hf  = '0;
    m_irq = 1'b0;
    for (int ch = 0; ch < NCH; ch++)
    begin
      m_cparm[ch] = '0;
      m_cmpl[ch]  = '0;
      m_cmph[ch]  = '0;
      m_cdata[ch] = '0;
    end
  endtask

  // advance the model by the current cycle's inputs
  task automatic model_step();
    logic       dev_wr;
    logic       clr_wr;
    logic       any_flag;
    logic [7:0] off;
    dev_wr   = wr && (addr[15:8] == `SDFM_DEVICE_ID);
    off      = addr[7:0];
    clr_wr   = dev_wr && (off == `SDFM_ADDR_IFLGCLR);
    any_flag = 1'b0;
    for (int ch = 0; ch < NCH; ch++)
      any_flag = any_flag || (m_lf[ch] && m_cparm[ch][ILEN_BIT])
                          || (m_hf[ch] && m_cparm[ch][IHEN_BIT]);
    // irq from the old state where set beats clear
    if (m_ctl[MIEN_BIT] && any_flag)
      m_irq = 1'b1;
    else if (clr_wr && wdata[`SDFM_IFLG_IRQF_BIT])
      m_irq = 1'b0;
    for (int ch = 0; ch < NCH; ch++)
    begin
      if (comp_update[ch])
        m_cdata[ch] = comp_data[ch*DW +: DW];
      if (comp_update[ch] && m_cparm[ch][LCLR_BIT])
        m_lf[ch] = comp_low[ch];
      else if (comp_update[ch] && comp_low[ch])
        m_lf[ch] = 1'b1;
      else if (!comp_update[ch] && clr_wr && wdata[`SDFM_IFLG_LF_BIT + ch])
        m_lf[ch] = 1'b0;
      if (comp_update[ch] && m_cparm[ch][HCLR_BIT])
        m_hf[ch] = comp_high[ch];
      else if (comp_update[ch] && comp_high[ch])
        m_hf[ch] = 1'b1;
      else if (!comp_update[ch] && clr_wr && wdata[`SDFM_IFLG_HF_BIT + ch])
        m_hf[ch] = 1'b0;
      if (dev_wr && off == 8'(`SDFM_ADDR_CPARM + 4 * ch))
        m_cparm[ch] = wdata & CPARM_MASK;
      if (dev_wr && off == 8'(`SDFM_ADDR_CMPL + 4 * ch))
        m_cmpl[ch] = wdata;
      if (dev_wr && off == 8'(`SDFM_ADDR_CMPH + 4 * ch))
        m_cmph[ch] = wdata;
    end
    if (dev_wr && off == `SDFM_ADDR_CTL)
      m_ctl = wdata & CTL_MASK;
  endtask

  task automatic check(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Error at time %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    end
  endtask

  //============================================================
  // compare process samples at the falling edge
  //============================================================
  always @(negedge SYSCLK)
  begin
    if (SYSRSTn)
    begin
      check("rdata", rd ? ref_rdata(addr) : '0, rdata);   // zero when rd is low
      check("irq", {31'b0, m_irq}, {31'b0, irq});
      check("rsten", {31'b0, m_ctl[0]}, {31'b0, rsten});
      check("clken", {31'b0, m_ctl[1]}, {31'b0, clken});
      for (int ch = 0; ch < NCH; ch++)
      begin
        check($sformatf("cparm outputs[%0d]", ch), m_cparm[ch], cparm_outputs(ch));
        check($sformatf("cmpl[%0d]", ch), m_cmpl[ch], cmpl[ch*DW +: DW]);
        check($sformatf("cmph[%0d]", ch), m_cmph[ch], cmph[ch*DW +: DW]);
      end
    end
    if (!SYSRSTn)
      model_reset();      // DUT resets at the coming edge
    else
      model_step();
  end

  //============================================================
  // stimulus helpers
  //============================================================
  task automatic bus_cycle(input logic w, input logic r, input logic [15:0] a,
                           input logic [DW-1:0] d);
    @(posedge SYSCLK);
    wr          <= w;
    rd          <= r;
    addr        <= a;
    wdata       <= d;
    comp_update <= '0;     // comparator strobes last one cycle
    comp_low    <= '0;
    comp_high   <= '0;
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [DW-1:0] d);
    bus_cycle(1'b1, 1'b0, a, d);
  endtask

  task automatic bus_read(input logic [15:0] a);
    bus_cycle(1'b0, 1'b1, a, $urandom);
  endtask

  task automatic bus_idle();
    bus_cycle(1'b0, 1'b0, 16'h0000, '0);
  endtask

  // same cycle as the preceding bus task
  task automatic comp_drive(input logic [NCH-1:0] upd, input logic [NCH-1:0] low,
                            input logic [NCH-1:0] high);
    comp_update <= upd;
    comp_low    <= low;
    comp_high   <= high;
    for (int ch = 0; ch < NCH; ch++)
      comp_data[ch*DW +: DW] <= $urandom;
  endtask

  function automatic logic [NCH-1:0] rand_mask();
    return NCH'($urandom_range(0, (1 << NCH) - 1));
  endfunction

  function automatic logic [DW-1:0] clear_all();
    logic [DW-1:0] w;
    w = '0;
    w[`SDFM_IFLG_LF_BIT +: NCH] = '1;
    w[`SDFM_IFLG_HF_BIT +: NCH] = '1;
    w[`SDFM_IFLG_IRQF_BIT]      = 1'b1;
    return w;
  endfunction

  task automatic read_all();
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    bus_read(reg_addr(`SDFM_ADDR_IFLGCLR, 0));
    bus_read(reg_addr(`SDFM_ADDR_CTL, 0));
    for (int ch = 0; ch < NCH; ch++)
    begin
      bus_read(reg_addr(`SDFM_ADDR_CPARM, ch));
      bus_read(reg_addr(`SDFM_ADDR_CMPL, ch));
      bus_read(reg_addr(`SDFM_ADDR_CMPH, ch));
      bus_read(reg_addr(`SDFM_ADDR_CDATA, ch));
    end
  endtask

  // idle first so the last read is already compared
  task automatic end_test(input string name);
    bus_idle();
    tests++;
    $display("test %-10s done, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  //============================================================
  // tests
  //============================================================
  task automatic test_write_read();
    int            sel;
    int            ch;
    logic [15:0]   a;
    repeat (40)
    begin
      sel = $urandom_range(0, 3);
      ch  = $urandom_range(0, NCH - 1);
      case (sel)
        0:       a = reg_addr(`SDFM_ADDR_CTL, 0);
        1:       a = reg_addr(`SDFM_ADDR_CPARM, ch);
        2:       a = reg_addr(`SDFM_ADDR_CMPL, ch);
        default: a = reg_addr(`SDFM_ADDR_CMPH, ch);
      endcase
      bus_write(a, $urandom);
      bus_read(a);                 // masked value back
    end
    read_all();
  endtask

  task automatic test_capture();
    for (int ch = 0; ch < NCH; ch++)
      bus_write(reg_addr(`SDFM_ADDR_CPARM, ch), '0);
    repeat (20)
    begin
      bus_idle();
      comp_drive(rand_mask(), '0, '0);   // some channels keep old data
      for (int ch = 0; ch < NCH; ch++)
        bus_read(reg_addr(`SDFM_ADDR_CDATA, ch));
    end
  endtask

  task automatic test_flags();
    logic [DW-1:0] hw_clr;
    hw_clr = '0;
    hw_clr[LCLR_BIT] = 1'b1;
    hw_clr[HCLR_BIT] = 1'b1;
    bus_write(reg_addr(`SDFM_ADDR_CTL, 0), '0);
    bus_write(reg_addr(`SDFM_ADDR_CPARM, 0), '0);         // ch0 sticky
    bus_write(reg_addr(`SDFM_ADDR_CPARM, NCH - 1), hw_clr); // last ch follows samples
    bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), clear_all());
    bus_idle();
    comp_drive('1, '1, '1);
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    bus_idle();
    comp_drive('1, '0, '0);
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    // update and clear in one cycle
    bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), clear_all());
    comp_drive(NCH'(1), NCH'(1), '0);
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    repeat (40)
    begin
      if ($urandom_range(0, 2) == 0)
        bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), $urandom);
      else
        bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
      comp_drive(rand_mask(), rand_mask(), rand_mask());
    end
  endtask

  task automatic test_irq();
    bus_write(reg_addr(`SDFM_ADDR_CTL, 0), 32'(1 << MIEN_BIT));
    bus_write(reg_addr(`SDFM_ADDR_CPARM, 0), 32'(1 << ILEN_BIT));
    bus_write(reg_addr(`SDFM_ADDR_CPARM, NCH - 1), 32'(1 << IHEN_BIT));
    bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), clear_all());
    bus_idle();
    comp_drive(NCH'(1), NCH'(1), '0);          // LF0 up and irq one cycle later
    bus_idle();
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), clear_all());  // flag still sets irq
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), 32'h8000_0000);
    bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    // irq must stay down with mien low
    bus_write(reg_addr(`SDFM_ADDR_CTL, 0), 32'h0000_0003);
    bus_idle();
    comp_drive('1, '1, '1);
    repeat (3)
      bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
    repeat (30)
    begin
      case ($urandom_range(0, 3))
        0:       bus_write(reg_addr(`SDFM_ADDR_CTL, 0), $urandom);
        1:       bus_write(reg_addr(`SDFM_ADDR_IFLGCLR, 0), $urandom);
        default: bus_read(reg_addr(`SDFM_ADDR_IFLG, 0));
      endcase
      comp_drive(rand_mask(), rand_mask(), rand_mask());
    end
  endtask

  task automatic test_unmapped();
    logic [7:0]  dev;
    logic [7:0]  off;
    repeat (30)
    begin
      if ($urandom_range(0, 1) == 1)
      begin
        do
          dev = 8'($urandom);
        while (dev == `SDFM_DEVICE_ID);
        off = 8'($urandom);
      end
      else
      begin
        dev = `SDFM_DEVICE_ID;
        do
          off = 8'($urandom);
        while (is_mapped(off));
      end
      bus_write({dev, off}, $urandom);
      bus_read({dev, off});
    end
    read_all();                          // registers must be unchanged
  endtask

  //============================================================
  // main sequence
  //============================================================
  initial
  begin
    void'($urandom(SEED));
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_err0   = 0;
    SYSRSTn     = 1'b0;
    wr          = 1'b0;
    rd          = 1'b0;
    addr        = '0;
    wdata       = '0;
    comp_update = '0;
    comp_data   = '0;
    comp_low    = '0;
    comp_high   = '0;
    repeat (RST_CYCLES) @(posedge SYSCLK);
    SYSRSTn <= 1'b1;

    read_all();
    end_test("reset");
    test_write_read();
    end_test("write_read");
    test_capture();
    end_test("capture");
    test_flags();
    end_test("flags");
    test_irq();
    end_test("irq");
    test_unmapped();
    end_test("unmapped");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog at twice the expected run length
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/sdfm_pkg.sv
hdl/sdfm_bus_decode.sv
hdl/sdfm_comp_channel.sv
hdl/sdfm_ctl_irq_read.sv
hdl/sdfm_regmap.sv
test/tb_clkgen.sv
test/tb_sdfm_regmap.sv

// ==== run.sh ====
#!/bin/sh
# build the sdfm register map testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_sdfm_regmap -o tb_sdfm_regmap --Mdir obj_dir \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sdfm_regmap > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0
